// File: verilog/fp_format_pkg.sv
package fp_format_pkg;

    // ieee-754 single-precision word, msb first
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fp_fields_t;

    // same word seen as a raw value or split into its fields
    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  fields;
    } fp_word_u;

    // per-operand class bits produced by the decode stage
    typedef struct packed {
        logic is_nan;
        logic is_snan;   // subset of is_nan
        logic is_zero;   // either sign
    } fp_class_t;

    localparam logic [31:0] FP_QNAN     = 32'h7FC0_0000;  // canonical quiet NaN
    localparam logic [31:0] FP_NEG_ZERO = 32'h8000_0000;
    localparam logic [7:0]  FP_EXP_MAX  = 8'hFF;          // inf / nan exponent

endpackage

// File: verilog/fp_unit_map_pkg.sv
package fp_unit_map_pkg;

    // command codes, written to bits 2:0 of CMD
    typedef enum logic [2:0] {
        FMIN   = 3'd0,
        FMAX   = 3'd1,
        FEQ    = 3'd2,
        FLT    = 3'd3,
        FLE    = 3'd4,
        FSGNJ  = 3'd5,
        FSGNJN = 3'd6,
        FSGNJX = 3'd7
    } fp_op_e;

    // register byte offsets
    localparam logic [4:0] REG_OPA    = 5'h00;
    localparam logic [4:0] REG_OPB    = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_RESULT = 5'h0C;  // read only
    localparam logic [4:0] REG_FLAGS  = 5'h10;

    // bits of FLAGS
    localparam int FLAGS_NV_BIT   = 0;  // sticky invalid, write 1 to clear
    localparam int FLAGS_BUSY_BIT = 1;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'd0;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'd2;

    // up to three operations in flight
    localparam int INFLIGHT_W = 2;

endpackage

// File: verilog/fp_stage_if.sv
`timescale 1ns/100ps

// one operation issued by the register block
interface fp_issue_if;
    import fp_unit_map_pkg::*;

    logic        valid;  // single-cycle pulse, no back-pressure
    fp_op_e      op;
    logic [31:0] a;
    logic [31:0] b;

    modport source (output valid, op, a, b);
    modport sink   (input  valid, op, a, b);
endinterface

// decoded operation handed from decode to execute
interface fp_class_if;
    import fp_format_pkg::*;
    import fp_unit_map_pkg::*;

    logic        valid;
    fp_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    fp_class_t   class_a;
    fp_class_t   class_b;
    logic        mag_lt;  // |a| < |b|
    logic        mag_gt;  // |a| > |b|

    modport source (output valid, op, a, b, class_a, class_b, mag_lt, mag_gt);
    modport sink   (input  valid, op, a, b, class_a, class_b, mag_lt, mag_gt);
endinterface

// File: verilog/fp_axil_regs.sv
`timescale 1ns/100ps

module fp_axil_regs (
    input  logic        clk,
    input  logic        rst,
    // write address / data / response
    input  logic [4:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    // read address / data
    input  logic [4:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    fp_issue_if.source  issue,
    input  logic [31:0] result,
    input  logic        nv_flag,
    input  logic        busy,
    output logic        flag_clear
);
    import fp_unit_map_pkg::*;

    logic [31:0] opa;
    logic [31:0] opb;
    fp_op_e      last_op;

    logic        wr_go;     // latched write is applied on this cycle
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic        wr_ok;
    logic        aw_take;

    logic [31:0] rd_data;
    logic        rd_ok;
    logic [31:0] flags_word;

    // only accept when nothing is waiting on the B channel
    assign aw_take = s_awvalid && s_wvalid && !s_awready && !wr_go && !s_bvalid;

    always_comb begin
        case (wr_addr)
            REG_OPA, REG_OPB, REG_CMD, REG_FLAGS: wr_ok = 1'b1;
            default:                              wr_ok = 1'b0;  // RESULT is read only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_awready   <= 1'b0;
            s_wready    <= 1'b0;
            s_bvalid    <= 1'b0;
            s_bresp     <= AXI_RESP_OKAY;
            wr_go       <= 1'b0;
            issue.valid <= 1'b0;
            flag_clear  <= 1'b0;
            last_op     <= FMIN;
        end else begin
            s_awready   <= aw_take;
            s_wready    <= aw_take;
            wr_go       <= s_awready && s_awvalid;
            issue.valid <= 1'b0;
            flag_clear  <= 1'b0;
            if (wr_go) begin
                s_bvalid <= 1'b1;
                s_bresp  <= wr_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
                if (wr_addr == REG_CMD) begin
                    last_op     <= fp_op_e'(wr_data[2:0]);
                    issue.valid <= 1'b1;
                end
                if (wr_addr == REG_FLAGS && wr_data[FLAGS_NV_BIT])
                    flag_clear <= 1'b1;
            end else if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    // address and data capture, operand registers
    always_ff @(posedge clk) begin
        if (s_awready && s_awvalid) begin
            wr_addr <= s_awaddr;
            wr_data <= s_wdata;  // strobes ignored
        end
        if (wr_go && wr_addr == REG_OPA)
            opa <= wr_data;
        if (wr_go && wr_addr == REG_OPB)
            opb <= wr_data;
    end

    // operands are stable while a CMD write is applied
    assign issue.op = last_op;
    assign issue.a  = opa;
    assign issue.b  = opb;

    always_comb begin
        flags_word                 = '0;
        flags_word[FLAGS_NV_BIT]   = nv_flag;
        flags_word[FLAGS_BUSY_BIT] = busy;
    end

    always_comb begin
        rd_ok = 1'b1;
        case (s_araddr)
            REG_OPA:    rd_data = opa;
            REG_OPB:    rd_data = opb;
            REG_CMD:    rd_data = {29'd0, last_op};
            REG_RESULT: rd_data = result;
            REG_FLAGS:  rd_data = flags_word;
            default: begin
                rd_data = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
            s_rresp   <= AXI_RESP_OKAY;
            s_rdata   <= '0;
        end else if (s_arready && s_arvalid) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b1;
            s_rdata   <= rd_data;
            s_rresp   <= rd_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end else if (s_rvalid) begin
            if (s_rready) begin
                s_rvalid  <= 1'b0;
                s_arready <= 1'b1;
            end
        end else begin
            s_arready <= 1'b1;  // idle, ready for the next address
        end
    end

endmodule

// File: verilog/fp_operand_decode.sv
`timescale 1ns/100ps

module fp_operand_decode (
    input  logic        clk,
    input  logic        rst,
    fp_issue_if.sink    issue,
    fp_class_if.source  cls
);
    import fp_format_pkg::*;

    fp_word_u  wa;
    fp_word_u  wb;
    fp_class_t ca;
    fp_class_t cb;
    logic      lt;
    logic      gt;

    function automatic fp_class_t classify(input fp_word_u w);
        fp_class_t c;
        c.is_nan  = (w.fields.exponent == FP_EXP_MAX) && (w.fields.fraction != '0);
        c.is_snan = c.is_nan && !w.fields.fraction[22];  // quiet bit clear
        c.is_zero = (w.fields.exponent == '0) && (w.fields.fraction != '0) == 1'b0;
        return c;
    endfunction

    always_comb begin
        wa.raw = issue.a;
        wb.raw = issue.b;
        ca     = classify(wa);
        cb     = classify(wb);
        // exponent first, then fraction
        lt = {wa.fields.exponent, wa.fields.fraction} < {wb.fields.exponent, wb.fields.fraction};
        gt = {wa.fields.exponent, wa.fields.fraction} > {wb.fields.exponent, wb.fields.fraction};
    end

    always_ff @(posedge clk) begin
        if (rst)
            cls.valid <= 1'b0;
        else
            cls.valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            cls.op      <= issue.op;
            cls.a       <= wa.raw;
            cls.b       <= wb.raw;
            cls.class_a <= ca;
            cls.class_b <= cb;
            cls.mag_lt  <= lt;
            cls.mag_gt  <= gt;
        end
    end

endmodule

// File: verilog/fp_cmp_execute.sv
`timescale 1ns/100ps

module fp_cmp_execute (
    input  logic        clk,
    input  logic        rst,
    fp_class_if.sink    cls,
    output logic        res_valid,
    output logic [31:0] res_value,
    output logic        res_invalid
);
    import fp_format_pkg::*;
    import fp_unit_map_pkg::*;

    fp_word_u    wa;
    fp_word_u    wb;
    fp_word_u    sgnj;
    logic        sa;
    logic        sb;
    logic        any_nan;
    logic        any_snan;
    logic        both_zero;
    logic        a_below;   // a < b as values, NaN aside
    logic        a_above;   // a > b as values, NaN aside
    logic        eq;
    logic        lt;
    logic [31:0] minmax;
    logic [31:0] value_d;
    logic        invalid_d;

    always_comb begin
        wa.raw    = cls.a;
        wb.raw    = cls.b;
        sa        = wa.fields.sign;
        sb        = wb.fields.sign;
        any_nan   = cls.class_a.is_nan | cls.class_b.is_nan;
        any_snan  = cls.class_a.is_snan | cls.class_b.is_snan;
        both_zero = cls.class_a.is_zero & cls.class_b.is_zero;

        if (both_zero) begin
            a_below = 1'b0;  // +0 and -0 compare equal
            a_above = 1'b0;
        end else if (sa != sb) begin
            a_below = sa;
            a_above = sb;
        end else if (sa) begin
            // both negative, larger magnitude is the smaller value
            a_below = cls.mag_gt;
            a_above = cls.mag_lt;
        end else begin
            a_below = cls.mag_lt;
            a_above = cls.mag_gt;
        end

        eq = !any_nan && !a_below && !a_above;
        lt = !any_nan && a_below;
    end

    // min / max, FMAX mirrors FMIN
    always_comb begin
        if (cls.class_a.is_nan && cls.class_b.is_nan)
            minmax = FP_QNAN;
        else if (cls.class_a.is_nan)
            minmax = cls.b;
        else if (cls.class_b.is_nan)
            minmax = cls.a;
        else if (both_zero && cls.op == FMAX)
            minmax = (sa & sb) ? FP_NEG_ZERO : '0;
        else if (both_zero)
            minmax = (sa | sb) ? FP_NEG_ZERO : '0;
        else if (cls.op == FMAX)
            minmax = a_below ? cls.b : cls.a;  // ties keep a
        else
            minmax = a_above ? cls.b : cls.a;
    end

    // sign injection keeps a's magnitude
    always_comb begin
        sgnj.raw = cls.a;
        case (cls.op)
            FSGNJ:   sgnj.fields.sign = sb;
            FSGNJN:  sgnj.fields.sign = ~sb;
            FSGNJX:  sgnj.fields.sign = sa ^ sb;
            default: sgnj.fields.sign = sa;
        endcase
    end

    always_comb begin
        case (cls.op)
            FMIN, FMAX: begin
                value_d   = minmax;
                invalid_d = any_snan;
            end
            FEQ: begin
                value_d   = {31'd0, eq};
                invalid_d = any_snan;
            end
            FLT: begin
                value_d   = {31'd0, lt};
                invalid_d = any_nan;  // signaling compare
            end
            FLE: begin
                value_d   = {31'd0, lt | eq};
                invalid_d = any_nan;
            end
            default: begin
                value_d   = sgnj.raw;
                invalid_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            res_valid <= 1'b0;
        else
            res_valid <= cls.valid;
    end

    always_ff @(posedge clk) begin
        if (cls.valid) begin
            res_value   <= value_d;
            res_invalid <= invalid_d;
        end
    end

endmodule

// File: verilog/fp_result_stage.sv
`timescale 1ns/100ps

module fp_result_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        res_valid,
    input  logic [31:0] res_value,
    input  logic        res_invalid,
    input  logic        issue_pulse,
    input  logic        flag_clear,
    output logic [31:0] result,
    output logic        nv_flag,
    output logic        busy
);
    import fp_unit_map_pkg::*;

    logic [INFLIGHT_W-1:0] inflight;

    always_ff @(posedge clk) begin
        if (rst) begin
            result   <= '0;
            nv_flag  <= 1'b0;
            inflight <= '0;
        end else begin
            if (res_valid)
                result <= res_value;

            if (res_valid && res_invalid)
                nv_flag <= 1'b1;  // set beats clear
            else if (flag_clear)
                nv_flag <= 1'b0;

            // issue and retire on the same cycle cancel out
            if (issue_pulse && !res_valid)
                inflight <= inflight + 1'b1;
            else if (res_valid && !issue_pulse)
                inflight <= inflight - 1'b1;
        end
    end

    assign busy = (inflight != '0);

endmodule

// File: verilog/fp_cmp_unit_top.sv
`timescale 1ns/100ps

module fp_cmp_unit_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [4:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready
);

    fp_issue_if issue_bus ();
    fp_class_if class_bus ();

    logic        res_valid;
    logic [31:0] res_value;
    logic        res_invalid;
    logic [31:0] result;
    logic        nv_flag;
    logic        busy;
    logic        flag_clear;

    fp_axil_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .issue      (issue_bus.source),
        .result     (result),
        .nv_flag    (nv_flag),
        .busy       (busy),
        .flag_clear (flag_clear)
    );

    fp_operand_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .issue (issue_bus.sink),
        .cls   (class_bus.source)
    );

    fp_cmp_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .cls         (class_bus.sink),
        .res_valid   (res_valid),
        .res_value   (res_value),
        .res_invalid (res_invalid)
    );

    fp_result_stage u_result (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res_value   (res_value),
        .res_invalid (res_invalid),
        .issue_pulse (issue_bus.valid),  // counts operations entering the pipe
        .flag_clear  (flag_clear),
        .result      (result),
        .nv_flag     (nv_flag),
        .busy        (busy)
    );

endmodule

// File: verification/tb_fp_cmp_unit.sv
`timescale 1ns/100ps

module tb_fp_cmp_unit;
    import fp_format_pkg::*;
    import fp_unit_map_pkg::*;

    localparam int N_OPS         = 8 * 64 + 2 * 200 + 6 * 40 + 2 + 8;
    localparam int XFERS_PER_OP  = 7;   // three writes, up to two polls, one read, margin
    localparam int N_XFERS       = N_OPS * XFERS_PER_OP + 40;
    localparam int MAX_CYCLES    = N_XFERS * 12 + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic [4:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [4:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    logic [31:0]      lfsr = 32'h0500_1310;
    logic             exp_nv = 1'b0;   // accumulated invalid flag of the model
    int               assert_errors = 0;
    int               check_errors = 0;
    int               cycles = 0;
    logic [31:0]      mon_a;
    logic [31:0]      mon_b;
    logic             cmd_hs;
    logic [4:0]       lat_v;           // bit k set when a CMD handshake happened k+1 edges ago
    logic [4:0][31:0] lat_val;
    logic             b_wait;
    logic [1:0]       b_resp_q;
    logic             r_wait;
    logic [31:0]      r_data_q;
    logic [1:0]       r_resp_q;

    fp_cmp_unit_top dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] special(input logic [2:0] k);
        case (k)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'h7F80_0000;  // +inf
            3'd3:    return 32'hFF80_0000;
            3'd4:    return 32'h7FC0_0000;  // quiet NaN
            3'd5:    return 32'hFFC0_0000;
            3'd6:    return 32'h7F80_0001;  // signaling NaN
            default: return 32'hFF80_0001;
        endcase
    endfunction

    // one draw in four is a special value
    task automatic gen_operand(output logic [31:0] v);
        logic [31:0] sel;
        take_bits(2, sel);
        if (sel == 32'd0) begin
            take_bits(3, sel);
            v = special(sel[2:0]);
        end else begin
            take_bits(32, v);
        end
    endtask

    function automatic logic is_nan(input logic [31:0] x);
        return x[30:23] == 8'hFF && x[22:0] != 23'd0;
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // maps a non-NaN value onto an unsigned scale in numeric order with both zeros on one point
    function automatic logic [31:0] order_key(input logic [31:0] x);
        if (x[30:0] == 31'd0)
            return 32'h8000_0000;
        else if (x[31])
            return ~x;
        else
            return x | 32'h8000_0000;
    endfunction

    function automatic logic [31:0] model_result(input fp_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [31:0] ka;
        logic [31:0] kb;
        logic        nan;
        ka  = order_key(a);
        kb  = order_key(b);
        nan = is_nan(a) || is_nan(b);
        case (op)
            FMIN, FMAX: begin
                if (is_nan(a) && is_nan(b))
                    return FP_QNAN;
                if (is_nan(a))
                    return b;
                if (is_nan(b))
                    return a;
                if (a[30:0] == 31'd0 && b[30:0] == 31'd0) begin
                    if (op == FMIN)
                        return (a[31] || b[31]) ? FP_NEG_ZERO : 32'd0;
                    return (a[31] && b[31]) ? FP_NEG_ZERO : 32'd0;
                end
                if (op == FMIN)
                    return (kb < ka) ? b : a;  // equal values keep a
                return (kb > ka) ? b : a;
            end
            FEQ:     return {31'd0, !nan && ka == kb};
            FLT:     return {31'd0, !nan && ka < kb};
            FLE:     return {31'd0, !nan && ka <= kb};
            FSGNJ:   return {b[31], a[30:0]};
            FSGNJN:  return {~b[31], a[30:0]};
            default: return {a[31] ^ b[31], a[30:0]};
        endcase
    endfunction

    function automatic logic model_invalid(input fp_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
        case (op)
            FMIN, FMAX, FEQ: return is_snan(a) || is_snan(b);
            FLT, FLE:        return is_nan(a) || is_nan(b);
            default:         return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            check_errors++;
            $display("Mismatch: %s expected %08h actual %08h", name, exp, got);
        end
    endtask

    // all bus tasks start and end on a rising edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic [31:0] hold;
        s_awaddr  <= addr;
        s_wdata   <= data;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        @(posedge clk);
        while (!s_awready)
            @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        take_bits(2, hold);
        repeat (hold) @(posedge clk);  // keep bready low for a while
        s_bready <= 1'b1;
        @(posedge clk);
        while (!s_bvalid)
            @(posedge clk);
        resp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic [31:0] hold;
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        @(posedge clk);
        while (!s_arready)
            @(posedge clk);
        s_arvalid <= 1'b0;
        take_bits(2, hold);
        repeat (hold) @(posedge clk);
        s_rready <= 1'b1;
        @(posedge clk);
        while (!s_rvalid)
            @(posedge clk);
        data = s_rdata;
        resp = s_rresp;
        s_rready <= 1'b0;
    endtask

    // poll FLAGS until busy reads 0
    task automatic wait_idle(output logic [31:0] flags);
        logic [1:0] resp;
        axi_read(REG_FLAGS, flags, resp);
        while (flags[FLAGS_BUSY_BIT])
            axi_read(REG_FLAGS, flags, resp);
    endtask

    task automatic run_op(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] flags;
        logic [31:0] got;
        logic [1:0]  resp;
        axi_write(REG_OPA, a, resp);
        axi_write(REG_OPB, b, resp);
        axi_write(REG_CMD, {29'd0, op}, resp);
        check("bresp", {30'd0, resp}, {30'd0, AXI_RESP_OKAY});
        exp_nv = exp_nv | model_invalid(op, a, b);
        wait_idle(flags);
        check("FLAGS", flags, {31'd0, exp_nv});
        axi_read(REG_RESULT, got, resp);
        check("RESULT", got, model_result(op, a, b));
    endtask

    task automatic clear_nv();
        logic [31:0] v;
        logic [1:0]  resp;
        axi_write(REG_FLAGS, 32'h1, resp);
        exp_nv = 1'b0;
        axi_read(REG_FLAGS, v, resp);
        check("FLAGS", v, 32'd0);
    endtask

    assign cmd_hs = s_awvalid && s_awready && s_awaddr == REG_CMD;

    // tracks operands and the expected result of each CMD through the pipeline
    always @(posedge clk) begin
        if (rst) begin
            lat_v  <= '0;
            b_wait <= 1'b0;
            r_wait <= 1'b0;
        end else begin
            if (s_awvalid && s_awready && s_awaddr == REG_OPA)
                mon_a <= s_wdata;
            if (s_awvalid && s_awready && s_awaddr == REG_OPB)
                mon_b <= s_wdata;
            lat_v    <= {lat_v[3:0], cmd_hs};
            lat_val  <= {lat_val[3:0], model_result(fp_op_e'(s_wdata[2:0]), mon_a, mon_b)};
            b_wait   <= s_bvalid && !s_bready;
            b_resp_q <= s_bresp;
            r_wait   <= s_rvalid && !s_rready;
            r_data_q <= s_rdata;
            r_resp_q <= s_rresp;
        end
    end

    assert property (@(posedge clk) disable iff (rst) lat_v[4] |-> dut.result == lat_val[4])
        else begin
            assert_errors++;
            $display("Mismatch: result expected %08h actual %08h",
                     $sampled(lat_val[4]), $sampled(dut.result));
        end

    assert property (@(posedge clk) disable iff (rst) dut.busy == (lat_v[2] || lat_v[3]))
        else begin
            assert_errors++;
            $display("Mismatch: busy expected %h actual %h",
                     $sampled(lat_v[2] || lat_v[3]), $sampled(dut.busy));
        end

    // address and data are accepted together in one cycle
    assert property (@(posedge clk) disable iff (rst) s_wready == s_awready)
        else begin
            assert_errors++;
            $display("Mismatch: wready expected %h actual %h",
                     $sampled(s_awready), $sampled(s_wready));
        end

    assert property (@(posedge clk) disable iff (rst) b_wait |-> s_bvalid)
        else begin
            assert_errors++;
            $display("write response was withdrawn while bready was low");
        end

    assert property (@(posedge clk) disable iff (rst) b_wait |-> s_bresp == b_resp_q)
        else begin
            assert_errors++;
            $display("Mismatch: bresp expected %h actual %h",
                     $sampled(b_resp_q), $sampled(s_bresp));
        end

    assert property (@(posedge clk) disable iff (rst) r_wait |-> s_rvalid)
        else begin
            assert_errors++;
            $display("read response was withdrawn while rready was low");
        end

    assert property (@(posedge clk) disable iff (rst) r_wait |-> s_rdata == r_data_q)
        else begin
            assert_errors++;
            $display("Mismatch: rdata expected %08h actual %08h",
                     $sampled(r_data_q), $sampled(s_rdata));
        end

    assert property (@(posedge clk) disable iff (rst) r_wait |-> s_rresp == r_resp_q)
        else begin
            assert_errors++;
            $display("Mismatch: rresp expected %h actual %h",
                     $sampled(r_resp_q), $sampled(s_rresp));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int          i;
        int          j;
        int          k;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [1:0]  resp;
        rst       <= 1'b1;
        s_awaddr  <= '0;
        s_awvalid <= 1'b0;
        s_wdata   <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b0;
        s_araddr  <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check("bvalid", {31'd0, s_bvalid}, 32'd0);
        check("rvalid", {31'd0, s_rvalid}, 32'd0);
        check("busy", {31'd0, dut.busy}, 32'd0);
        axi_read(REG_RESULT, v, resp);
        check("RESULT", v, 32'd0);
        axi_read(REG_FLAGS, v, resp);
        check("FLAGS", v, 32'd0);

        // every op over all pairs of special values
        for (k = 0; k < 8; k++)
            for (i = 0; i < 8; i++)
                for (j = 0; j < 8; j++)
                    run_op(fp_op_e'(k[2:0]), special(i[2:0]), special(j[2:0]));
        clear_nv();

        for (i = 0; i < 200; i++) begin
            gen_operand(a);
            gen_operand(b);
            run_op(FMIN, a, b);
            run_op(FMAX, a, b);
        end
        clear_nv();

        for (i = 0; i < 40; i++) begin
            gen_operand(a);
            gen_operand(b);
            for (k = 2; k < 8; k++)
                run_op(fp_op_e'(k[2:0]), a, b);
        end
        clear_nv();

        // CMD writes one after another without waiting for results
        a = 32'h7F80_0001;
        b = 32'hBF80_0000;
        axi_write(REG_OPA, a, resp);
        axi_write(REG_OPB, b, resp);
        for (k = 0; k < 8; k++) begin
            axi_write(REG_CMD, k, resp);
            exp_nv = exp_nv | model_invalid(fp_op_e'(k[2:0]), a, b);
        end
        wait_idle(v);
        check("FLAGS", v, {31'd0, exp_nv});
        axi_read(REG_RESULT, v, resp);
        check("RESULT", v, model_result(FSGNJX, a, b));

        // rejected writes leave every register alone
        run_op(FLT, 32'h7FC0_0000, 32'h0000_0000);
        run_op(FSGNJN, 32'h3F80_0000, 32'h4000_0000);
        axi_write(5'h14, 32'hFFFF_FFFF, resp);
        check("bresp", {30'd0, resp}, {30'd0, AXI_RESP_SLVERR});
        axi_write(REG_RESULT, 32'hFFFF_FFFF, resp);
        check("bresp", {30'd0, resp}, {30'd0, AXI_RESP_SLVERR});
        axi_read(REG_OPA, v, resp);
        check("OPA", v, 32'h3F80_0000);
        axi_read(REG_OPB, v, resp);
        check("OPB", v, 32'h4000_0000);
        axi_read(REG_CMD, v, resp);
        check("CMD", v, {29'd0, FSGNJN});
        axi_read(REG_RESULT, v, resp);
        check("RESULT", v, 32'hBF80_0000);
        axi_read(REG_FLAGS, v, resp);
        check("FLAGS", v, 32'h1);
        axi_read(5'h14, v, resp);
        check("rresp", {30'd0, resp}, {30'd0, AXI_RESP_SLVERR});

        repeat (2) @(posedge clk);
        $display("%0d assertion errors, %0d check errors", assert_errors, check_errors);
        if (assert_errors == 0 && check_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: sim.f
verilog/fp_format_pkg.sv
verilog/fp_unit_map_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_axil_regs.sv
verilog/fp_operand_decode.sv
verilog/fp_cmp_execute.sv
verilog/fp_result_stage.sv
verilog/fp_cmp_unit_top.sv
verification/tb_fp_cmp_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fp compare unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_fp_cmp_unit \
    -o tb_fp_cmp_unit

./obj_dir/tb_fp_cmp_unit | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
